// ==== bus_defs.svh ====
// Map pages are 4 KB and each end page is exclusive; BUS_SID_W must stay BUS_MID_W plus one
`ifndef BUS_DEFS_SVH
`define BUS_DEFS_SVH

`define BUS_ADDR_W 32
`define BUS_DATA_W 32
`define BUS_STRB_W 4

`define BUS_MST_N 2
`define BUS_SLV_N 3            // Last slot is the error subordinate

`define BUS_MID_W 2
`define BUS_SID_W (`BUS_MID_W + 1)  // Manager index in bit 0

`define RAM_WORDS 256

// Address bits 31:12
`define MAP0_START 20'h00000
`define MAP0_END 20'h00001
`define MAP1_START 20'h00001
`define MAP1_END 20'h00002

`endif

// ==== bus_pkg.sv ====
// Types for the two-manager crossbar; BUS_MAP covers the RAM slots only, misses go to the error slot
`include "bus_defs.svh"

package bus_pkg;

    // ID on the manager side of the crossbar
    typedef logic [`BUS_MID_W-1:0] mst_id_t;

    // Manager ID in the upper bits, manager index in bit 0
    typedef logic [`BUS_SID_W-1:0] slv_id_t;

    typedef logic [1:0] resp_t;

    localparam resp_t RESP_OKAY = 2'b00;
    localparam resp_t RESP_DECERR = 2'b11;

    typedef struct packed {
        logic [19:0] start_page;
        logic [19:0] end_page;    // Exclusive
    } map_entry_t;

    localparam map_entry_t BUS_MAP [`BUS_SLV_N-1] = '{
        '{start_page: `MAP0_START, end_page: `MAP0_END},
        '{start_page: `MAP1_START, end_page: `MAP1_END}
    };

endpackage

// ==== axi_if.sv ====
// Single-beat AXI4 with IDs only; no bursts, WLAST, USER, cache or protection signals
`timescale 1ns/1ps
`include "bus_defs.svh"

interface axi_if #(
    parameter type id_t = logic
) ();
    import bus_pkg::*;

    logic awvalid;
    logic awready;
    logic [`BUS_ADDR_W-1:0] awaddr;
    id_t awid;

    logic wvalid;
    logic wready;
    logic [`BUS_DATA_W-1:0] wdata;
    logic [`BUS_STRB_W-1:0] wstrb;

    logic bvalid;
    logic bready;
    resp_t bresp;
    id_t bid;

    logic arvalid;
    logic arready;
    logic [`BUS_ADDR_W-1:0] araddr;
    id_t arid;

    logic rvalid;
    logic rready;
    logic [`BUS_DATA_W-1:0] rdata;
    resp_t rresp;
    id_t rid;

    // Requesting side
    modport mgr (
        output awvalid, awaddr, awid, wvalid, wdata, wstrb, bready,
        output arvalid, araddr, arid, rready,
        input awready, wready, bvalid, bresp, bid,
        input arready, rvalid, rdata, rresp, rid
    );

    modport sub (
        input awvalid, awaddr, awid, wvalid, wdata, wstrb, bready,
        input arvalid, araddr, arid, rready,
        output awready, wready, bvalid, bresp, bid,
        output arready, rvalid, rdata, rresp, rid
    );

endinterface

// ==== axi_err_slave.sv ====
// Answers DECERR to every request, one read and one write in flight; write data is dropped
`timescale 1ns/1ps
`include "bus_defs.svh"

module axi_err_slave (
    input logic i_clk,
    input logic i_nrst,
    axi_if.sub  i_bus
);
    import bus_pkg::*;

    logic aw_hold;      // AW taken, W still due
    logic bvalid_q;
    logic rvalid_q;
    slv_id_t bid_q;
    slv_id_t rid_q;
    logic aw_fire;
    logic w_fire;
    logic ar_fire;

    assign aw_fire = i_bus.awvalid && !aw_hold && !bvalid_q;
    assign w_fire = i_bus.wvalid && aw_hold;
    assign ar_fire = i_bus.arvalid && !rvalid_q;

    assign i_bus.awready = !aw_hold && !bvalid_q;
    assign i_bus.wready = aw_hold;
    assign i_bus.bvalid = bvalid_q;
    assign i_bus.bresp = RESP_DECERR;
    assign i_bus.bid = bid_q;
    assign i_bus.arready = !rvalid_q;    // Next AR only after R
    assign i_bus.rvalid = rvalid_q;
    assign i_bus.rdata = '1;
    assign i_bus.rresp = RESP_DECERR;
    assign i_bus.rid = rid_q;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            aw_hold <= 1'b0;
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            if (aw_fire) aw_hold <= 1'b1;
            else if (w_fire) aw_hold <= 1'b0;

            if (w_fire) bvalid_q <= 1'b1;
            else if (i_bus.bready) bvalid_q <= 1'b0;

            if (ar_fire) rvalid_q <= 1'b1;
            else if (i_bus.rready) rvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (aw_fire) bid_q <= i_bus.awid;
        if (ar_fire) rid_q <= i_bus.arid;
    end

endmodule

// ==== axi_ram_slave.sv ====
// RAM_WORDS words at address bits 9:2, upper bits ignored; contents are undefined after power-up
`timescale 1ns/1ps
`include "bus_defs.svh"

module axi_ram_slave (
    input logic i_clk,
    input logic i_nrst,
    axi_if.sub  i_bus
);
    import bus_pkg::*;

    localparam int IDX_W = $clog2(`RAM_WORDS);

    logic [`BUS_DATA_W-1:0] mem [`RAM_WORDS];
    logic aw_hold;
    logic [IDX_W-1:0] aw_idx;
    logic bvalid_q;
    logic rvalid_q;
    slv_id_t bid_q;
    slv_id_t rid_q;
    logic [`BUS_DATA_W-1:0] rdata_q;
    logic aw_fire;
    logic w_fire;
    logic ar_fire;

    assign aw_fire = i_bus.awvalid && !aw_hold && !bvalid_q;
    assign w_fire = i_bus.wvalid && aw_hold;
    assign ar_fire = i_bus.arvalid && !rvalid_q;

    assign i_bus.awready = !aw_hold && !bvalid_q;   // Free again after B
    assign i_bus.wready = aw_hold;
    assign i_bus.bvalid = bvalid_q;
    assign i_bus.bresp = RESP_OKAY;
    assign i_bus.bid = bid_q;
    assign i_bus.arready = !rvalid_q;
    assign i_bus.rvalid = rvalid_q;
    assign i_bus.rdata = rdata_q;
    assign i_bus.rresp = RESP_OKAY;
    assign i_bus.rid = rid_q;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            aw_hold <= 1'b0;
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            if (aw_fire) aw_hold <= 1'b1;
            else if (w_fire) aw_hold <= 1'b0;

            if (w_fire) bvalid_q <= 1'b1;
            else if (i_bus.bready) bvalid_q <= 1'b0;

            if (ar_fire) rvalid_q <= 1'b1;
            else if (i_bus.rready) rvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (aw_fire) begin
            aw_idx <= i_bus.awaddr[IDX_W+1:2];
            bid_q <= i_bus.awid;
        end
        // Byte lane merge
        if (w_fire) begin
            for (int b = 0; b < `BUS_STRB_W; b++) begin
                if (i_bus.wstrb[b]) mem[aw_idx][8*b +: 8] <= i_bus.wdata[8*b +: 8];
            end
        end
        if (ar_fire) begin
            rdata_q <= mem[i_bus.araddr[IDX_W+1:2]];
            rid_q <= i_bus.arid;
        end
    end

endmodule

// ==== axi_xbar.sv ====
// Fixed priority with manager 0 highest; a manager needs its W beat done before its next AW
`timescale 1ns/1ps
`include "bus_defs.svh"

module axi_xbar (
    input logic i_clk,
    input logic i_nrst,
    axi_if.sub  i_mst [`BUS_MST_N],
    axi_if.mgr  o_slv [`BUS_SLV_N-1]
);
    import bus_pkg::*;

    localparam int M = `BUS_MST_N;
    localparam int S = `BUS_SLV_N;
    localparam int SEL_W = $clog2(S);
    localparam int MIDX_W = `BUS_SID_W - `BUS_MID_W;

    // Manager side, flattened
    logic m_awvalid [M], m_awready [M], m_wvalid [M], m_wready [M];
    logic m_bvalid [M], m_bready [M], m_arvalid [M], m_arready [M];
    logic m_rvalid [M], m_rready [M];
    logic [`BUS_ADDR_W-1:0] m_awaddr [M], m_araddr [M];
    logic [`BUS_DATA_W-1:0] m_wdata [M], m_rdata [M];
    logic [`BUS_STRB_W-1:0] m_wstrb [M];
    mst_id_t m_awid [M], m_arid [M], m_bid [M], m_rid [M];
    resp_t m_bresp [M], m_rresp [M];

    // Subordinate side, error slot last
    logic s_awvalid [S], s_awready [S], s_wvalid [S], s_wready [S];
    logic s_bvalid [S], s_bready [S], s_arvalid [S], s_arready [S];
    logic s_rvalid [S], s_rready [S];
    logic [`BUS_ADDR_W-1:0] s_awaddr [S], s_araddr [S];
    logic [`BUS_DATA_W-1:0] s_wdata [S], s_rdata [S];
    logic [`BUS_STRB_W-1:0] s_wstrb [S];
    slv_id_t s_awid [S], s_arid [S], s_bid [S], s_rid [S];
    resp_t s_bresp [S], s_rresp [S];

    logic [SEL_W-1:0] w_sel [M];       // Slot that owns the pending W beat
    logic [SEL_W-1:0] w_sel_nxt [M];
    logic [M-1:0] w_act;
    logic [M-1:0] w_act_nxt;

    axi_if #(.id_t(slv_id_t)) err_bus ();

    axi_err_slave err_i (
        .i_clk (i_clk),
        .i_nrst(i_nrst),
        .i_bus (err_bus)
    );

    function automatic logic [SEL_W-1:0] decode(input logic [`BUS_ADDR_W-1:0] addr);
        logic [SEL_W-1:0] slot;
        slot = SEL_W'(S - 1);    // Miss
        for (int ii = 0; ii < S - 1; ii++) begin
            if (BUS_MAP[ii].start_page <= addr[`BUS_ADDR_W-1:12]
                    && addr[`BUS_ADDR_W-1:12] < BUS_MAP[ii].end_page) begin
                slot = SEL_W'(ii);
            end
        end
        return slot;
    endfunction

    for (genvar i = 0; i < M; i++) begin : g_mst
        assign m_awvalid[i] = i_mst[i].awvalid;
        assign m_awaddr[i] = i_mst[i].awaddr;
        assign m_awid[i] = i_mst[i].awid;
        assign m_wvalid[i] = i_mst[i].wvalid;
        assign m_wdata[i] = i_mst[i].wdata;
        assign m_wstrb[i] = i_mst[i].wstrb;
        assign m_bready[i] = i_mst[i].bready;
        assign m_arvalid[i] = i_mst[i].arvalid;
        assign m_araddr[i] = i_mst[i].araddr;
        assign m_arid[i] = i_mst[i].arid;
        assign m_rready[i] = i_mst[i].rready;
        assign i_mst[i].awready = m_awready[i];
        assign i_mst[i].wready = m_wready[i];
        assign i_mst[i].bvalid = m_bvalid[i];
        assign i_mst[i].bresp = m_bresp[i];
        assign i_mst[i].bid = m_bid[i];
        assign i_mst[i].arready = m_arready[i];
        assign i_mst[i].rvalid = m_rvalid[i];
        assign i_mst[i].rdata = m_rdata[i];
        assign i_mst[i].rresp = m_rresp[i];
        assign i_mst[i].rid = m_rid[i];
    end

    for (genvar ii = 0; ii < S - 1; ii++) begin : g_slv
        assign o_slv[ii].awvalid = s_awvalid[ii];
        assign o_slv[ii].awaddr = s_awaddr[ii];
        assign o_slv[ii].awid = s_awid[ii];
        assign o_slv[ii].wvalid = s_wvalid[ii];
        assign o_slv[ii].wdata = s_wdata[ii];
        assign o_slv[ii].wstrb = s_wstrb[ii];
        assign o_slv[ii].bready = s_bready[ii];
        assign o_slv[ii].arvalid = s_arvalid[ii];
        assign o_slv[ii].araddr = s_araddr[ii];
        assign o_slv[ii].arid = s_arid[ii];
        assign o_slv[ii].rready = s_rready[ii];
        assign s_awready[ii] = o_slv[ii].awready;
        assign s_wready[ii] = o_slv[ii].wready;
        assign s_bvalid[ii] = o_slv[ii].bvalid;
        assign s_bresp[ii] = o_slv[ii].bresp;
        assign s_bid[ii] = o_slv[ii].bid;
        assign s_arready[ii] = o_slv[ii].arready;
        assign s_rvalid[ii] = o_slv[ii].rvalid;
        assign s_rdata[ii] = o_slv[ii].rdata;
        assign s_rresp[ii] = o_slv[ii].rresp;
        assign s_rid[ii] = o_slv[ii].rid;
    end

    // Error slot
    assign err_bus.awvalid = s_awvalid[S-1];
    assign err_bus.awaddr = s_awaddr[S-1];
    assign err_bus.awid = s_awid[S-1];
    assign err_bus.wvalid = s_wvalid[S-1];
    assign err_bus.wdata = s_wdata[S-1];
    assign err_bus.wstrb = s_wstrb[S-1];
    assign err_bus.bready = s_bready[S-1];
    assign err_bus.arvalid = s_arvalid[S-1];
    assign err_bus.araddr = s_araddr[S-1];
    assign err_bus.arid = s_arid[S-1];
    assign err_bus.rready = s_rready[S-1];
    assign s_awready[S-1] = err_bus.awready;
    assign s_wready[S-1] = err_bus.wready;
    assign s_bvalid[S-1] = err_bus.bvalid;
    assign s_bresp[S-1] = err_bus.bresp;
    assign s_bid[S-1] = err_bus.bid;
    assign s_arready[S-1] = err_bus.arready;
    assign s_rvalid[S-1] = err_bus.rvalid;
    assign s_rdata[S-1] = err_bus.rdata;
    assign s_rresp[S-1] = err_bus.rresp;
    assign s_rid[S-1] = err_bus.rid;

    always_comb begin
        logic [S-1:0] ar_free;
        logic [S-1:0] aw_free;
        logic [SEL_W-1:0] dst;
        logic [MIDX_W-1:0] mi;

        ar_free = '1;
        aw_free = '1;
        w_sel_nxt = w_sel;
        w_act_nxt = w_act;
        s_awvalid = '{default: '0};
        s_awaddr = '{default: '0};
        s_awid = '{default: '0};
        s_wvalid = '{default: '0};
        s_wdata = '{default: '0};
        s_wstrb = '{default: '0};
        s_bready = '{default: '0};
        s_arvalid = '{default: '0};
        s_araddr = '{default: '0};
        s_arid = '{default: '0};
        s_rready = '{default: '0};
        m_awready = '{default: '0};
        m_wready = '{default: '0};
        m_bvalid = '{default: '0};
        m_bresp = '{default: '0};
        m_bid = '{default: '0};
        m_arready = '{default: '0};
        m_rvalid = '{default: '0};
        m_rdata = '{default: '0};
        m_rresp = '{default: '0};
        m_rid = '{default: '0};

        for (int i = 0; i < M; i++) begin
            dst = decode(m_araddr[i]);
            if (m_arvalid[i] && ar_free[dst]) begin
                ar_free[dst] = 1'b0;             // Lower index already holds it
                s_arvalid[dst] = 1'b1;
                s_araddr[dst] = m_araddr[i];
                s_arid[dst] = {m_arid[i], MIDX_W'(i)};
                m_arready[i] = s_arready[dst];
            end

            dst = decode(m_awaddr[i]);
            if (m_awvalid[i] && !w_act[i] && aw_free[dst]) begin
                aw_free[dst] = 1'b0;
                s_awvalid[dst] = 1'b1;
                s_awaddr[dst] = m_awaddr[i];
                s_awid[dst] = {m_awid[i], MIDX_W'(i)};
                m_awready[i] = s_awready[dst];
                if (s_awready[dst]) begin
                    w_sel_nxt[i] = dst;
                    w_act_nxt[i] = 1'b1;
                end
            end

            // W follows the registered select, so it starts the cycle after AW
            if (w_act[i]) begin
                s_wvalid[w_sel[i]] = m_wvalid[i];
                s_wdata[w_sel[i]] = m_wdata[i];
                s_wstrb[w_sel[i]] = m_wstrb[i];
                m_wready[i] = s_wready[w_sel[i]];
                if (m_wvalid[i] && s_wready[w_sel[i]]) w_act_nxt[i] = 1'b0;
            end
        end

        // Responses, first valid slot per manager wins
        for (int ii = 0; ii < S; ii++) begin
            mi = s_bid[ii][MIDX_W-1:0];
            if (s_bvalid[ii] && !m_bvalid[mi]) begin
                m_bvalid[mi] = 1'b1;
                m_bresp[mi] = s_bresp[ii];
                m_bid[mi] = s_bid[ii][`BUS_SID_W-1:MIDX_W];
                s_bready[ii] = m_bready[mi];
            end
            mi = s_rid[ii][MIDX_W-1:0];
            if (s_rvalid[ii] && !m_rvalid[mi]) begin
                m_rvalid[mi] = 1'b1;
                m_rdata[mi] = s_rdata[ii];
                m_rresp[mi] = s_rresp[ii];
                m_rid[mi] = s_rid[ii][`BUS_SID_W-1:MIDX_W];
                s_rready[ii] = m_rready[mi];
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            w_act <= '0;
            w_sel <= '{default: '0};
        end else begin
            w_act <= w_act_nxt;
            w_sel <= w_sel_nxt;
        end
    end

endmodule

// ==== bus_top.sv ====
// Two managers, RAMs at pages 0 and 1, everything else decodes to DECERR; one write per manager
`timescale 1ns/1ps
`include "bus_defs.svh"

module bus_top (
    input  logic                   i_clk,
    input  logic                   i_nrst,
    input  logic                   i_m_awvalid [`BUS_MST_N],
    input  logic [`BUS_ADDR_W-1:0] i_m_awaddr  [`BUS_MST_N],
    input  bus_pkg::mst_id_t       i_m_awid    [`BUS_MST_N],
    output logic                   o_m_awready [`BUS_MST_N],
    input  logic                   i_m_wvalid  [`BUS_MST_N],
    input  logic [`BUS_DATA_W-1:0] i_m_wdata   [`BUS_MST_N],
    input  logic [`BUS_STRB_W-1:0] i_m_wstrb   [`BUS_MST_N],
    output logic                   o_m_wready  [`BUS_MST_N],
    output logic                   o_m_bvalid  [`BUS_MST_N],
    output bus_pkg::resp_t         o_m_bresp   [`BUS_MST_N],
    output bus_pkg::mst_id_t       o_m_bid     [`BUS_MST_N],
    input  logic                   i_m_bready  [`BUS_MST_N],
    input  logic                   i_m_arvalid [`BUS_MST_N],
    input  logic [`BUS_ADDR_W-1:0] i_m_araddr  [`BUS_MST_N],
    input  bus_pkg::mst_id_t       i_m_arid    [`BUS_MST_N],
    output logic                   o_m_arready [`BUS_MST_N],
    output logic                   o_m_rvalid  [`BUS_MST_N],
    output logic [`BUS_DATA_W-1:0] o_m_rdata   [`BUS_MST_N],
    output bus_pkg::resp_t         o_m_rresp   [`BUS_MST_N],
    output bus_pkg::mst_id_t       o_m_rid     [`BUS_MST_N],
    input  logic                   i_m_rready  [`BUS_MST_N]
);
    import bus_pkg::*;

    axi_if #(.id_t(mst_id_t)) mst_bus [`BUS_MST_N] ();
    axi_if #(.id_t(slv_id_t)) slv_bus [`BUS_SLV_N-1] ();

    for (genvar i = 0; i < `BUS_MST_N; i++) begin : g_mst
        assign mst_bus[i].awvalid = i_m_awvalid[i];
        assign mst_bus[i].awaddr = i_m_awaddr[i];
        assign mst_bus[i].awid = i_m_awid[i];
        assign mst_bus[i].wvalid = i_m_wvalid[i];
        assign mst_bus[i].wdata = i_m_wdata[i];
        assign mst_bus[i].wstrb = i_m_wstrb[i];
        assign mst_bus[i].bready = i_m_bready[i];
        assign mst_bus[i].arvalid = i_m_arvalid[i];
        assign mst_bus[i].araddr = i_m_araddr[i];
        assign mst_bus[i].arid = i_m_arid[i];
        assign mst_bus[i].rready = i_m_rready[i];
        assign o_m_awready[i] = mst_bus[i].awready;
        assign o_m_wready[i] = mst_bus[i].wready;
        assign o_m_bvalid[i] = mst_bus[i].bvalid;
        assign o_m_bresp[i] = mst_bus[i].bresp;
        assign o_m_bid[i] = mst_bus[i].bid;
        assign o_m_arready[i] = mst_bus[i].arready;
        assign o_m_rvalid[i] = mst_bus[i].rvalid;
        assign o_m_rdata[i] = mst_bus[i].rdata;
        assign o_m_rresp[i] = mst_bus[i].rresp;
        assign o_m_rid[i] = mst_bus[i].rid;
    end

    axi_xbar xbar_i (
        .i_clk (i_clk),
        .i_nrst(i_nrst),
        .i_mst (mst_bus),
        .o_slv (slv_bus)
    );

    // One RAM per mapped slot
    for (genvar j = 0; j < `BUS_SLV_N - 1; j++) begin : g_ram
        axi_ram_slave ram_i (
            .i_clk (i_clk),
            .i_nrst(i_nrst),
            .i_bus (slv_bus[j])
        );
    end

endmodule

// ==== tb_bus_top.sv ====
// Directed tests for the two-manager crossbar; RAM words are only read after a full-strobe write
`timescale 1ns/1ps
`include "bus_defs.svh"

module tb_bus_top;

    localparam int M = `BUS_MST_N;
    localparam int CYCLE_LIMIT = 2000;      // About forty transactions of up to fifty cycles
    localparam logic [1:0] OKAY = 2'b00;
    localparam logic [1:0] DECERR = 2'b11;

    logic clk = 1'b0;
    logic nrst;

    logic awvalid [M];
    logic [31:0] awaddr [M];
    logic [1:0] awid [M];
    logic awready [M];
    logic wvalid [M];
    logic [31:0] wdata [M];
    logic [3:0] wstrb [M];
    logic wready [M];
    logic bvalid [M];
    logic [1:0] bresp [M];
    logic [1:0] bid [M];
    logic bready [M];
    logic arvalid [M];
    logic [31:0] araddr [M];
    logic [1:0] arid [M];
    logic arready [M];
    logic rvalid [M];
    logic [31:0] rdata [M];
    logic [1:0] rresp [M];
    logic [1:0] rid [M];
    logic rready [M];

    logic [31:0] model_mem [2][256];        // Expected RAM contents, slot then word
    logic [31:0] lcg_state = 32'd58;
    int errors = 0;
    int checks = 0;
    int cycles = 0;
    time r_done [M];                        // Edge of the last R transfer per manager

    bus_top dut_i (
        .i_clk      (clk),
        .i_nrst     (nrst),
        .i_m_awvalid(awvalid),
        .i_m_awaddr (awaddr),
        .i_m_awid   (awid),
        .o_m_awready(awready),
        .i_m_wvalid (wvalid),
        .i_m_wdata  (wdata),
        .i_m_wstrb  (wstrb),
        .o_m_wready (wready),
        .o_m_bvalid (bvalid),
        .o_m_bresp  (bresp),
        .o_m_bid    (bid),
        .i_m_bready (bready),
        .i_m_arvalid(arvalid),
        .i_m_araddr (araddr),
        .i_m_arid   (arid),
        .o_m_arready(arready),
        .o_m_rvalid (rvalid),
        .o_m_rdata  (rdata),
        .o_m_rresp  (rresp),
        .o_m_rid    (rid),
        .i_m_rready (rready)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, a handshake never completed", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // RAMs sit on pages 0 and 1, anything else misses
    function automatic int map_slot(input logic [31:0] addr);
        if (addr[31:12] == 20'h00000) return 0;
        if (addr[31:12] == 20'h00001) return 1;
        return -1;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                                input logic [3:0] strb);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) res[8*b +: 8] = data[8*b +: 8];
        end
        return res;
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    // Starts and ends 1 ns after a rising edge
    task automatic write_txn(input int m, input logic [31:0] addr, input logic [1:0] id,
                             input logic [31:0] data, input logic [3:0] strb);
        int slot;
        int lat;
        slot = map_slot(addr);
        awvalid[m] = 1'b1;
        awaddr[m] = addr;
        awid[m] = id;
        do begin
            @(negedge clk);
        end while (!awready[m]);
        @(posedge clk);
        #1;
        awvalid[m] = 1'b0;
        wvalid[m] = 1'b1;   // Data goes out after the AW transfer
        wdata[m] = data;
        wstrb[m] = strb;
        do begin
            @(negedge clk);
        end while (!wready[m]);
        @(posedge clk);
        #1;
        wvalid[m] = 1'b0;
        bready[m] = 1'b1;
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (!bvalid[m]);
        check_val($sformatf("o_m_bvalid[%0d] delay", m), 1, lat);
        check_val($sformatf("o_m_bresp[%0d]", m), (slot < 0) ? DECERR : OKAY, bresp[m]);
        check_val($sformatf("o_m_bid[%0d]", m), id, bid[m]);
        @(posedge clk);
        #1;
        bready[m] = 1'b0;
        if (slot >= 0) begin
            model_mem[slot][addr[9:2]] = merge_bytes(model_mem[slot][addr[9:2]], data, strb);
        end
    endtask

    task automatic read_txn(input int m, input logic [31:0] addr, input logic [1:0] id,
                            input int hold);
        int slot;
        int lat;
        logic [31:0] exp_data;
        logic [31:0] first_data;
        slot = map_slot(addr);
        exp_data = (slot < 0) ? 32'hffff_ffff : model_mem[slot][addr[9:2]];
        arvalid[m] = 1'b1;
        araddr[m] = addr;
        arid[m] = id;
        rready[m] = (hold == 0);
        do begin
            @(negedge clk);
        end while (!arready[m]);
        @(posedge clk);
        #1;
        arvalid[m] = 1'b0;
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (!rvalid[m]);
        check_val($sformatf("o_m_rvalid[%0d] delay", m), 1, lat);
        first_data = rdata[m];
        for (int k = 0; k < hold; k++) begin
            @(negedge clk);
            check_val($sformatf("o_m_rvalid[%0d] held", m), 1, rvalid[m]);
            check_val($sformatf("o_m_rdata[%0d] held", m), first_data, rdata[m]);
        end
        if (!rready[m]) begin
            @(posedge clk);
            #1;
            rready[m] = 1'b1;
            @(negedge clk);
        end
        check_val($sformatf("o_m_rdata[%0d]", m), exp_data, rdata[m]);
        check_val($sformatf("o_m_rresp[%0d]", m), (slot < 0) ? DECERR : OKAY, rresp[m]);
        check_val($sformatf("o_m_rid[%0d]", m), id, rid[m]);
        @(posedge clk);
        r_done[m] = $time;
        #1;
        rready[m] = 1'b0;
    endtask

    task automatic idle_after_reset();
        @(negedge clk);
        for (int i = 0; i < M; i++) begin
            check_val($sformatf("o_m_bvalid[%0d]", i), 0, bvalid[i]);
            check_val($sformatf("o_m_rvalid[%0d]", i), 0, rvalid[i]);
            check_val($sformatf("o_m_wready[%0d]", i), 0, wready[i]);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic mgr0_ram_rw();
        logic [31:0] a;
        for (int s = 0; s < 2; s++) begin
            a = {20'(s), 12'h010};
            write_txn(0, a, 2'd0, next_rand(), 4'hf);
            write_txn(0, a + 4, 2'd0, next_rand(), 4'hf);
            write_txn(0, a, 2'd0, next_rand(), 4'b0101);
            write_txn(0, a + 4, 2'd0, next_rand(), 4'b1000);
            read_txn(0, a, 2'd0, 0);
            read_txn(0, a + 4, 2'd0, 0);
        end
    endtask

    // Nonzero IDs come back without the manager index bit
    task automatic mgr1_id_return();
        logic [31:0] a;
        for (int s = 0; s < 2; s++) begin
            a = {20'(s), 12'h100};
            write_txn(1, a, 2'd1 + 2'(s), next_rand(), 4'hf);
            write_txn(1, a, 2'd3, next_rand(), 4'b0011);
            read_txn(1, a, 2'd2 + 2'(s), 0);
            read_txn(1, a, 2'd3, 0);
        end
    endtask

    task automatic decode_error_rw();
        write_txn(0, 32'h0000_5000, 2'd2, next_rand(), 4'hf);
        read_txn(0, 32'h0000_5000, 2'd1, 0);
        write_txn(1, 32'h0000_5010, 2'd3, next_rand(), 4'hf);   // Low bits alias RAM word 4
        read_txn(1, 32'h8000_0000, 2'd0, 0);
        read_txn(0, 32'h0000_0010, 2'd0, 0);
        read_txn(1, 32'h0000_1010, 2'd1, 0);
    endtask

    task automatic ar_contention();
        fork
            read_txn(0, 32'h0000_0010, 2'd1, 0);
            read_txn(1, 32'h0000_0010, 2'd2, 0);
            begin
                @(negedge clk);
                check_val("o_m_arready[0] on contention", 1, arready[0]);
                check_val("o_m_arready[1] on contention", 0, arready[1]);
            end
        join
    endtask

    task automatic concurrent_writes();
        fork
            write_txn(0, 32'h0000_0040, 2'd1, next_rand(), 4'hf);
            write_txn(1, 32'h0000_1040, 2'd1, next_rand(), 4'hf);
            begin
                @(negedge clk);   // Different RAMs, so no stall on AW
                check_val("o_m_awready[0] on separate RAMs", 1, awready[0]);
                check_val("o_m_awready[1] on separate RAMs", 1, awready[1]);
            end
        join
        read_txn(0, 32'h0000_0040, 2'd0, 0);
        read_txn(0, 32'h0000_1040, 2'd1, 0);
        read_txn(1, 32'h0000_0040, 2'd2, 0);
        read_txn(1, 32'h0000_1040, 2'd3, 0);
    endtask

    // Manager 1 must wait for the stalled R of manager 0 on the same RAM
    task automatic held_read();
        fork
            read_txn(0, 32'h0000_1040, 2'd2, 5);
            begin
                @(posedge clk);
                #1;
                read_txn(1, 32'h0000_1040, 2'd3, 0);
            end
        join
        check_val("o_m_rvalid[1] transfer after o_m_rvalid[0]", 1, 32'(r_done[1] > r_done[0]));
    endtask

    initial begin
        nrst = 1'b0;
        for (int i = 0; i < M; i++) begin
            awvalid[i] = 1'b0;
            awaddr[i] = '0;
            awid[i] = '0;
            wvalid[i] = 1'b0;
            wdata[i] = '0;
            wstrb[i] = '0;
            bready[i] = 1'b0;
            arvalid[i] = 1'b0;
            araddr[i] = '0;
            arid[i] = '0;
            rready[i] = 1'b0;
            r_done[i] = 0;
        end
        repeat (8) @(posedge clk);
        #1;
        nrst = 1'b1;
        idle_after_reset();
        mgr0_ram_rw();
        mgr1_id_return();
        decode_error_rw();
        ar_contention();
        concurrent_writes();
        held_read();
        repeat (2) @(posedge clk);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+.
bus_pkg.sv
axi_if.sv
axi_err_slave.sv
axi_ram_slave.sv
axi_xbar.sv
bus_top.sv
tb_bus_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_bus_top
FLIST     ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

SRCS := $(wildcard *.sv *.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(BUILD_DIR)
